// File: src/sdram_check_pkg.sv
`default_nettype none

package sdram_check_pkg;

    ////////////////////////////////////////
    // Widths with a meaning.
    ////////////////////////////////////////

    typedef logic [23:0] sdram_addr_t; // Bank(2) + row(13) + column(9).
    typedef logic [15:0] sdram_word_t; // One SDRAM data word.
    typedef logic [7:0]  uart_byte_t;  // Serial payload byte.
    typedef logic [1:0]  word_index_t; // Word within a burst.
    typedef logic [2:0]  byte_index_t; // Byte within a burst, 0 to 7.

    // Self-test steps.
    typedef enum logic [2:0] {
        WRITE_BURST,  // Hold write request until done.
        READ_BURST,   // Hold read request until done.
        COMPARE_BYTE, // Check one byte of the read-back.
        SEND_BYTE,    // Wait for the serial frame.
        PAUSE,        // Gap between rounds.
        HALT_ERROR,   // Mismatch seen, led on.
        TEST_DONE     // Last address finished.
    } check_state_t;

    ////////////////////////////////////////
    // Constants.
    ////////////////////////////////////////

    localparam int BURST_WORDS = 4; // Four-word burst mode.
    localparam int ADDR_STEP   = 4; // One burst per round.

    // 133.33 MHz / 115200 baud.
    localparam int DEFAULT_BIT_CYCLES = 1157;

    // Roughly 16.7 ms between rounds.
    localparam int DEFAULT_PAUSE_CYCLES = 2222222;

    // Start of last burst in a 480x800 frame.
    localparam int DEFAULT_LAST_ADDR = 383996;

    localparam int FRAME_BITS = 11; // Start, eight data, two stop.

endpackage

`default_nettype wire

// File: src/pattern_generator.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_generator #(
    parameter int LAST_ADDR = sdram_check_pkg::DEFAULT_LAST_ADDR
) (
    input  logic                         clk_133MHz_210,
    input  logic                         rst_n,
    input  logic                         advance,   // Step to next round.
    output sdram_check_pkg::sdram_addr_t rw_addr,   // Burst start address.
    output sdram_check_pkg::sdram_word_t test_word, // Written to all four words.
    output logic                         last_addr  // Current round is the last.
);

    ////////////////////////////////////////
    // Address and data pattern.
    ////////////////////////////////////////

    // New values one cycle after advance.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            rw_addr   <= '0;
            test_word <= '0;
        end else if (advance) begin
            rw_addr   <= rw_addr + sdram_check_pkg::sdram_addr_t'(sdram_check_pkg::ADDR_STEP);
            test_word <= test_word + 1'b1; // Round n writes n.
        end
    end

    assign last_addr = (rw_addr == sdram_check_pkg::sdram_addr_t'(LAST_ADDR));

    // Bursts stay aligned across all rounds.
    assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        (rw_addr % sdram_check_pkg::ADDR_STEP) == 0);

endmodule

`default_nettype wire

// File: src/readback_comparator.sv
`timescale 1ns/1ns
`default_nettype none

module readback_comparator (
    input  logic                         clk_133MHz_210,
    input  logic                         rst_n,
    input  logic                         capture,   // Latch read burst.
    input  sdram_check_pkg::sdram_word_t rd_data0,
    input  sdram_check_pkg::sdram_word_t rd_data1,
    input  sdram_check_pkg::sdram_word_t rd_data2,
    input  sdram_check_pkg::sdram_word_t rd_data3,
    input  sdram_check_pkg::sdram_word_t test_word, // Expected value.
    input  sdram_check_pkg::byte_index_t byte_sel,  // Byte under test.
    output sdram_check_pkg::uart_byte_t  tx_byte,   // Byte to send.
    output logic                         word_bad   // Whole word mismatch.
);

    sdram_check_pkg::sdram_word_t rd_word [sdram_check_pkg::BURST_WORDS]; // Read-back.
    sdram_check_pkg::word_index_t word_idx;
    sdram_check_pkg::sdram_word_t sel_word;

    ////////////////////////////////////////
    // Read-back capture.
    ////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < sdram_check_pkg::BURST_WORDS; w++) begin
                rd_word[w] <= '0;
            end
        end else if (capture) begin
            rd_word[0] <= rd_data0;
            rd_word[1] <= rd_data1;
            rd_word[2] <= rd_data2;
            rd_word[3] <= rd_data3;
        end
    end

    ////////////////////////////////////////
    // Compare and byte select.
    ////////////////////////////////////////

    // Two bytes per word.
    assign word_idx = byte_sel[2:1];
    assign sel_word = rd_word[word_idx];

    // Both bytes of a word fail together.
    assign word_bad = (sel_word != test_word);

    // Even index is high byte, sent first.
    assign tx_byte = byte_sel[0] ? sel_word[7:0] : sel_word[15:8];

endmodule

`default_nettype wire

// File: src/uart_byte_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_byte_tx #(
    parameter int BIT_CYCLES = sdram_check_pkg::DEFAULT_BIT_CYCLES
) (
    input  logic                        clk_133MHz_210,
    input  logic                        rst_n,
    input  logic                        tx_start, // Begin frame.
    input  sdram_check_pkg::uart_byte_t tx_data,
    output logic                        uart_txd, // Serial line, idle high.
    output logic                        tx_done   // Last cycle of second stop bit.
);

    logic [$clog2(BIT_CYCLES + 1)-1:0]               cyc_cnt;   // Cycles within a bit.
    logic [$clog2(sdram_check_pkg::FRAME_BITS)-1:0]  bit_cnt;   // Bit within the frame.
    logic [sdram_check_pkg::FRAME_BITS-2:0]          shift_reg; // Bits after start bit.
    logic                                            busy;
    logic                                            bit_end;
    logic                                            frame_end;

    assign bit_end   = busy && (cyc_cnt == $bits(cyc_cnt)'(BIT_CYCLES - 1));
    assign frame_end = bit_end
                    && (bit_cnt == $bits(bit_cnt)'(sdram_check_pkg::FRAME_BITS - 1));
    assign tx_done   = frame_end;

    ////////////////////////////////////////
    // Bit timing and line drive.
    ////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            cyc_cnt  <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;
        end else if (tx_start) begin
            busy     <= 1'b1;
            cyc_cnt  <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b0; // Start bit.
        end else if (busy) begin
            if (bit_end) begin
                cyc_cnt <= '0;
                if (frame_end) begin
                    busy     <= 1'b0;
                    uart_txd <= 1'b1; // Back to idle.
                end else begin
                    bit_cnt  <= bit_cnt + 1'b1;
                    uart_txd <= shift_reg[0]; // LSB first.
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // Payload shifter, data then two stop bits.
    always_ff @(posedge clk_133MHz_210) begin
        if (tx_start) begin
            shift_reg <= {2'b11, tx_data};
        end else if (bit_end && !frame_end) begin
            shift_reg <= {1'b1, shift_reg[sdram_check_pkg::FRAME_BITS-2:1]};
        end
    end

    // Sequencer waits for tx_done before the next byte.
    assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        tx_start |-> !busy);

endmodule

`default_nettype wire

// File: src/check_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module check_sequencer #(
    parameter int PAUSE_CYCLES = sdram_check_pkg::DEFAULT_PAUSE_CYCLES
) (
    input  logic                         clk_133MHz_210,
    input  logic                         rst_n,
    input  logic                         wr_done,   // Memory finished write.
    input  logic                         rd_done,   // Memory finished read.
    input  logic                         word_bad,  // From comparator.
    input  logic                         tx_done,   // Frame sent.
    input  logic                         last_addr, // Round at final address.
    output logic                         wr_req,
    output logic                         rd_req,
    output logic                         capture,   // Same cycle as rd_done.
    output logic                         tx_start,  // First cycle of SEND_BYTE.
    output logic                         advance,   // End of pause.
    output logic                         led,
    output sdram_check_pkg::byte_index_t byte_sel
);

    sdram_check_pkg::check_state_t       state;
    logic [$clog2(PAUSE_CYCLES + 1)-1:0] pause_cnt; // Cycles spent in PAUSE.
    logic                                pause_end;

    // Last cycle of the pause.
    assign pause_end = (state == sdram_check_pkg::PAUSE)
                    && (pause_cnt == $bits(pause_cnt)'(PAUSE_CYCLES - 1));

    // Read data sits on the bus only with rd_done.
    assign capture = (state == sdram_check_pkg::READ_BURST) && rd_done;

    // No advance after the last round, address stays put.
    assign advance = pause_end && !last_addr;

    ////////////////////////////////////////
    // Self-test FSM.
    ////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sdram_check_pkg::WRITE_BURST;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
            tx_start  <= 1'b0;
            byte_sel  <= '0;
            pause_cnt <= '0;
            led       <= 1'b0;
        end else begin
            tx_start <= 1'b0; // Strobe.
            case (state)
                sdram_check_pkg::WRITE_BURST: begin
                    if (wr_done) begin
                        wr_req <= 1'b0; // Drop in cycle after done.
                        state  <= sdram_check_pkg::READ_BURST;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                sdram_check_pkg::READ_BURST: begin
                    if (rd_done) begin
                        rd_req   <= 1'b0;
                        byte_sel <= '0; // Word 0 high byte first.
                        state    <= sdram_check_pkg::COMPARE_BYTE;
                    end else begin
                        rd_req <= 1'b1;
                    end
                end
                sdram_check_pkg::COMPARE_BYTE: begin
                    if (word_bad) begin
                        led   <= 1'b1; // Halt, nothing more is sent.
                        state <= sdram_check_pkg::HALT_ERROR;
                    end else begin
                        tx_start <= 1'b1;
                        state    <= sdram_check_pkg::SEND_BYTE;
                    end
                end
                sdram_check_pkg::SEND_BYTE: begin
                    if (tx_done) begin
                        // Byte 7 is the low byte of word 3.
                        if (byte_sel == sdram_check_pkg::byte_index_t'(7)) begin
                            pause_cnt <= '0;
                            state     <= sdram_check_pkg::PAUSE;
                        end else begin
                            byte_sel <= byte_sel + 1'b1;
                            state    <= sdram_check_pkg::COMPARE_BYTE;
                        end
                    end
                end
                sdram_check_pkg::PAUSE: begin
                    if (pause_end) begin
                        pause_cnt <= '0;
                        state     <= last_addr ? sdram_check_pkg::TEST_DONE
                                               : sdram_check_pkg::WRITE_BURST;
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                sdram_check_pkg::HALT_ERROR,
                sdram_check_pkg::TEST_DONE: begin
                    state <= state; // Terminal, wait for reset.
                end
                default: begin
                    state <= sdram_check_pkg::WRITE_BURST;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////

    // One burst in flight, never both directions.
    assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(wr_req && rd_req));

    // Frames start only from the send step.
    assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        tx_start |-> (state == sdram_check_pkg::SEND_BYTE));

endmodule

`default_nettype wire

// File: src/sdram_check_top.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_check_top #(
    parameter int BIT_CYCLES   = sdram_check_pkg::DEFAULT_BIT_CYCLES,
    parameter int PAUSE_CYCLES = sdram_check_pkg::DEFAULT_PAUSE_CYCLES,
    parameter int LAST_ADDR    = sdram_check_pkg::DEFAULT_LAST_ADDR
) (
    input  logic                         clk_133MHz_210, // 133 MHz, 210 degree phase.
    input  logic                         rst_n,

    // Memory side.
    output logic                         wr_req,   // Level, held until wr_done.
    output logic                         rd_req,   // Level, held until rd_done.
    output sdram_check_pkg::sdram_addr_t rw_addr,  // Burst start address.
    output sdram_check_pkg::sdram_word_t wr_data0,
    output sdram_check_pkg::sdram_word_t wr_data1,
    output sdram_check_pkg::sdram_word_t wr_data2,
    output sdram_check_pkg::sdram_word_t wr_data3,
    input  logic                         wr_done,  // One-cycle pulse.
    input  logic                         rd_done,  // One-cycle pulse, data valid.
    input  sdram_check_pkg::sdram_word_t rd_data0,
    input  sdram_check_pkg::sdram_word_t rd_data1,
    input  sdram_check_pkg::sdram_word_t rd_data2,
    input  sdram_check_pkg::sdram_word_t rd_data3,

    // Status.
    output logic                         uart_txd, // Idle high.
    output logic                         led       // High on mismatch.
);

    ////////////////////////////////////////
    // Internal nets.
    ////////////////////////////////////////

    logic                         capture;   // Latch read burst.
    logic                         word_bad;  // Selected word differs.
    logic                         tx_start;  // Start one frame.
    logic                         tx_done;   // Frame finished.
    logic                         advance;   // Next round.
    logic                         last_addr; // At final burst.
    sdram_check_pkg::byte_index_t byte_sel;
    sdram_check_pkg::uart_byte_t  tx_byte;
    sdram_check_pkg::sdram_word_t test_word; // Same value in all four slots.

    assign wr_data0 = test_word;
    assign wr_data1 = test_word;
    assign wr_data2 = test_word;
    assign wr_data3 = test_word;

    check_sequencer #(
        .PAUSE_CYCLES (PAUSE_CYCLES)
    ) seq_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wr_done        (wr_done),
        .rd_done        (rd_done),
        .word_bad       (word_bad),
        .tx_done        (tx_done),
        .last_addr      (last_addr),
        .wr_req         (wr_req),
        .rd_req         (rd_req),
        .capture        (capture),
        .tx_start       (tx_start),
        .advance        (advance),
        .led            (led),
        .byte_sel       (byte_sel)
    );

    pattern_generator #(
        .LAST_ADDR (LAST_ADDR)
    ) pat_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .advance        (advance),
        .rw_addr        (rw_addr),
        .test_word      (test_word),
        .last_addr      (last_addr)
    );

    readback_comparator cmp_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .capture        (capture),
        .rd_data0       (rd_data0),
        .rd_data1       (rd_data1),
        .rd_data2       (rd_data2),
        .rd_data3       (rd_data3),
        .test_word      (test_word),
        .byte_sel       (byte_sel),
        .tx_byte        (tx_byte),
        .word_bad       (word_bad)
    );

    uart_byte_tx #(
        .BIT_CYCLES (BIT_CYCLES)
    ) tx_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_data        (tx_byte),
        .uart_txd       (uart_txd),
        .tx_done        (tx_done)
    );

endmodule

`default_nettype wire

// File: tb/burst_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module burst_mem_model (
    input  logic                         clk_133MHz_210,
    input  logic                         rst_n,
    input  logic                         wr_req,
    input  logic                         rd_req,
    input  sdram_check_pkg::sdram_addr_t rw_addr,
    input  sdram_check_pkg::sdram_word_t wr_data0,
    input  sdram_check_pkg::sdram_word_t wr_data1,
    input  sdram_check_pkg::sdram_word_t wr_data2,
    input  sdram_check_pkg::sdram_word_t wr_data3,
    input  logic                         fault_en,    // Corrupt one read.
    input  int                           fault_round, // Round of the bad read.
    input  sdram_check_pkg::word_index_t fault_word,  // Word of the bad read.
    output logic                         wr_done,
    output logic                         rd_done,
    output sdram_check_pkg::sdram_word_t rd_data0,
    output sdram_check_pkg::sdram_word_t rd_data1,
    output sdram_check_pkg::sdram_word_t rd_data2,
    output sdram_check_pkg::sdram_word_t rd_data3
);

    sdram_check_pkg::sdram_word_t mem [0:63]; // Low address window only.
    sdram_check_pkg::sdram_word_t rd_buf [0:3];
    integer seed;
    int     delay;  // Cycles left until done.
    logic   busy;   // Request accepted.

    initial begin
        seed     = 32'hd15e_4cbb;
        busy     = 1'b0;
        delay    = 0;
        wr_done  = 1'b0;
        rd_done  = 1'b0;
        rd_data0 = '0;
        rd_data1 = '0;
        rd_data2 = '0;
        rd_data3 = '0;
    end

    // Answers on the falling edge, so the DUT sees stable levels.
    always @(negedge clk_133MHz_210) begin
        wr_done = 1'b0; // Pulses last one cycle.
        rd_done = 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
        end else if (!busy && (wr_req || rd_req)) begin
            busy  = 1'b1;
            delay = ($random(seed) & 3) + 1; // 1 to 4 cycles.
        end else if (busy) begin
            delay = delay - 1;
            if (delay == 0) begin
                busy = 1'b0;
                if (wr_req) begin
                    mem[rw_addr[5:0]]        = wr_data0;
                    mem[rw_addr[5:0] + 6'd1] = wr_data1;
                    mem[rw_addr[5:0] + 6'd2] = wr_data2;
                    mem[rw_addr[5:0] + 6'd3] = wr_data3;
                    wr_done = 1'b1;
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        rd_buf[w] = mem[rw_addr[5:0] + 6'(w)];
                    end
                    // Flip every bit of the chosen word.
                    if (fault_en && rw_addr == 24'(4 * fault_round)) begin
                        rd_buf[fault_word] = ~rd_buf[fault_word];
                    end
                    rd_data0 = rd_buf[0];
                    rd_data1 = rd_buf[1];
                    rd_data2 = rd_buf[2];
                    rd_data3 = rd_buf[3];
                    rd_done  = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/sdram_check_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_check_tb;

    localparam int BIT_CYCLES   = 8;
    localparam int PAUSE_CYCLES = 20;
    localparam int LAST_ADDR    = 12;    // Four rounds.
    localparam int NUM_RUNS     = 5;
    localparam int RUN_TIMEOUT  = 10000; // Cycles for one run.
    localparam int QUIET_CYCLES = 400;   // Idle window after the end.

    logic                         clk_133MHz_210;
    logic                         rst_n;
    logic                         wr_req;
    logic                         rd_req;
    sdram_check_pkg::sdram_addr_t rw_addr;
    sdram_check_pkg::sdram_word_t wr_data0;
    sdram_check_pkg::sdram_word_t wr_data1;
    sdram_check_pkg::sdram_word_t wr_data2;
    sdram_check_pkg::sdram_word_t wr_data3;
    logic                         wr_done;
    logic                         rd_done;
    sdram_check_pkg::sdram_word_t rd_data0;
    sdram_check_pkg::sdram_word_t rd_data1;
    sdram_check_pkg::sdram_word_t rd_data2;
    sdram_check_pkg::sdram_word_t rd_data3;
    logic                         uart_txd;
    logic                         led;
    logic                         fault_en;
    int                           fault_round;
    sdram_check_pkg::word_index_t fault_word;

    // Run table.
    string run_name  [NUM_RUNS];
    logic  run_fault [NUM_RUNS];
    int    run_round [NUM_RUNS];
    int    run_word  [NUM_RUNS];
    int    run_bytes [NUM_RUNS]; // 8r + 2k with a fault, 32 without.
    logic  run_led   [NUM_RUNS];

    logic [7:0] rx_bytes [$]; // Bytes seen on uart_txd.
    string      cur_name;
    int         run_errors;
    int         total_errors;
    int         passed;
    int         failed;
    int         rounds;       // Reads seen in this run.
    logic       expect_write; // Next request must be a write.
    logic       prev_wr;
    logic       prev_rd;

    sdram_check_top #(
        .BIT_CYCLES   (BIT_CYCLES),
        .PAUSE_CYCLES (PAUSE_CYCLES),
        .LAST_ADDR    (LAST_ADDR)
    ) dut_i (
        .clk_133MHz_210 (clk_133MHz_210), .rst_n (rst_n),
        .wr_req (wr_req), .rd_req (rd_req), .rw_addr (rw_addr),
        .wr_data0 (wr_data0), .wr_data1 (wr_data1),
        .wr_data2 (wr_data2), .wr_data3 (wr_data3),
        .wr_done (wr_done), .rd_done (rd_done),
        .rd_data0 (rd_data0), .rd_data1 (rd_data1),
        .rd_data2 (rd_data2), .rd_data3 (rd_data3),
        .uart_txd (uart_txd), .led (led)
    );

    burst_mem_model mem_i (
        .clk_133MHz_210 (clk_133MHz_210), .rst_n (rst_n),
        .wr_req (wr_req), .rd_req (rd_req), .rw_addr (rw_addr),
        .wr_data0 (wr_data0), .wr_data1 (wr_data1),
        .wr_data2 (wr_data2), .wr_data3 (wr_data3),
        .fault_en (fault_en), .fault_round (fault_round), .fault_word (fault_word),
        .wr_done (wr_done), .rd_done (rd_done),
        .rd_data0 (rd_data0), .rd_data1 (rd_data1),
        .rd_data2 (rd_data2), .rd_data3 (rd_data3)
    );

    initial begin
        clk_133MHz_210 = 1'b0;
        forever #50 clk_133MHz_210 = ~clk_133MHz_210; // 100 ns period.
    end

    task automatic value_mismatch(input string what, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
        $display("error %s: %s expected 0x%0h actual 0x%0h", cur_name, what, exp_val, act_val);
        run_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", cur_name, msg);
        run_errors++;
    endtask

    task automatic add_row(input int idx, input string name, input logic fault,
                           input int rnd, input int word, input int bytes, input logic exp_led);
        run_name[idx]  = name;
        run_fault[idx] = fault;
        run_round[idx] = rnd;
        run_word[idx]  = word;
        run_bytes[idx] = bytes;
        run_led[idx]   = exp_led;
    endtask

    ////////////////////////////////////////
    // Memory request monitor.
    ////////////////////////////////////////

    always @(negedge clk_133MHz_210) begin
        if (rst_n) begin
            if (wr_req && rd_req) note_failure("write and read requests were high together");
            if (wr_req && !prev_wr) begin // New write.
                if (!expect_write) note_failure("a write came before the read of its round");
                if (rw_addr !== 24'(4 * rounds)) begin
                    value_mismatch("write address", 4 * rounds, rw_addr);
                end
                if ({wr_data0, wr_data1, wr_data2, wr_data3} !== {4{16'(rounds)}}) begin
                    value_mismatch("write data", {4{16'(rounds)}},
                                   {wr_data0, wr_data1, wr_data2, wr_data3});
                end
                expect_write = 1'b0;
            end
            if (rd_req && !prev_rd) begin // New read.
                if (expect_write) note_failure("a read came without a write before it");
                if (rw_addr !== 24'(4 * rounds)) begin
                    value_mismatch("read address", 4 * rounds, rw_addr);
                end
                expect_write = 1'b1;
                rounds++;
            end
        end
        prev_wr = wr_req;
        prev_rd = rd_req;
    end

    ////////////////////////////////////////
    // Serial receiver, mid-bit sampling.
    ////////////////////////////////////////

    initial begin : serial_rx
        logic [7:0] rx_byte;
        logic       frame_ok;
        forever begin
            @(negedge clk_133MHz_210);
            if (rst_n && uart_txd === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk_133MHz_210); // Middle of start bit.
                frame_ok = (uart_txd === 1'b0);
                for (int b = 0; b < 8; b++) begin
                    repeat (BIT_CYCLES) @(negedge clk_133MHz_210);
                    rx_byte[b] = uart_txd; // LSB first.
                end
                repeat (2) begin
                    repeat (BIT_CYCLES) @(negedge clk_133MHz_210);
                    frame_ok = frame_ok && (uart_txd === 1'b1);
                end
                if (!frame_ok) note_failure("a serial frame had a bad start or stop bit");
                rx_bytes.push_back(rx_byte);
            end
        end
    end

    task automatic apply_reset(input int r);
        @(negedge clk_133MHz_210);
        rst_n        = 1'b0;
        fault_en     = run_fault[r];
        fault_round  = run_round[r];
        fault_word   = sdram_check_pkg::word_index_t'(run_word[r]);
        rounds       = 0;
        expect_write = 1'b1;
        rx_bytes.delete();
        repeat (3) @(negedge clk_133MHz_210);
        if ({wr_req, rd_req, led, uart_txd} !== 4'b0001) begin
            value_mismatch("reset wr_req rd_req led txd", 4'b0001,
                           {wr_req, rd_req, led, uart_txd});
        end
        rst_n = 1'b1;
    endtask

    ////////////////////////////////////////
    // Run loop.
    ////////////////////////////////////////

    initial begin : main
        int         t;
        logic       busy_seen;
        logic [7:0] exp_byte;
        rst_n = 1'b0;
        fault_en = 1'b0;
        fault_round = 0;
        fault_word = '0;
        total_errors = 0;
        passed = 0;
        failed = 0;
        add_row(0, "no_fault", 1'b0, 0, 0, 32, 1'b0);
        add_row(1, "fault_r0_w0", 1'b1, 0, 0, 0, 1'b1);
        add_row(2, "fault_r1_w2", 1'b1, 1, 2, 12, 1'b1);
        add_row(3, "fault_r2_w1", 1'b1, 2, 1, 18, 1'b1);
        add_row(4, "fault_r3_w3", 1'b1, 3, 3, 30, 1'b1);
        for (int r = 0; r < NUM_RUNS; r++) begin
            cur_name   = run_name[r];
            run_errors = 0;
            apply_reset(r);
            t = 0;
            while (!(rx_bytes.size() >= run_bytes[r] && led === run_led[r])
                   && t < RUN_TIMEOUT) begin
                @(negedge clk_133MHz_210);
                t++;
            end
            if (t >= RUN_TIMEOUT) note_failure("timed out waiting for the self-test to stop");
            busy_seen = 1'b0;
            repeat (QUIET_CYCLES) begin // Nothing may follow the end.
                @(negedge clk_133MHz_210);
                if (wr_req || rd_req || uart_txd !== 1'b1) busy_seen = 1'b1;
            end
            if (busy_seen) note_failure("memory or serial activity after the test stopped");
            if (led !== run_led[r]) value_mismatch("final led", run_led[r], led);
            if (rx_bytes.size() != run_bytes[r]) begin
                value_mismatch("byte count", run_bytes[r], rx_bytes.size());
            end
            for (int i = 0; i < rx_bytes.size() && i < run_bytes[r]; i++) begin
                exp_byte = (i % 2 == 0) ? 8'((i / 8) >> 8) : 8'(i / 8); // High byte first.
                if (rx_bytes[i] !== exp_byte) begin
                    value_mismatch($sformatf("byte %0d", i), exp_byte, rx_bytes[i]);
                end
            end
            if (run_errors == 0) begin
                passed++;
                $display("run %s: pass", cur_name);
            end else begin
                failed++;
                $display("run %s: fail with %0d errors", cur_name, run_errors);
            end
            total_errors += run_errors;
        end
        $display("runs %0d, passed %0d, failed %0d, errors %0d",
                 NUM_RUNS, passed, failed, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sdram_check_top.f
src/sdram_check_pkg.sv
src/pattern_generator.sv
src/readback_comparator.sv
src/uart_byte_tx.sv
src/check_sequencer.sv
src/sdram_check_top.sv
tb/burst_mem_model.sv
tb/sdram_check_tb.sv
